// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pwm_chain_tb
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = simulation.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/compare_unit.sv
// Compare stage; shadowed thresholds turn counter values into registered match bits
`timescale 1ns/1ps

module compare_unit (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              counter_stopped,
    input  logic [pwm_pkg::counter_width-1:0] count,
    input  logic                              reload,
    input  logic [pwm_pkg::counter_width-1:0] threshold_set [pwm_pkg::n_channels],
    input  logic [pwm_pkg::counter_width-1:0] threshold_clear [pwm_pkg::n_channels],
    output logic [pwm_pkg::n_channels-1:0]    match_set,
    output logic [pwm_pkg::n_channels-1:0]    match_clear
);

    logic [pwm_pkg::counter_width-1:0] shadow_set [pwm_pkg::n_channels];
    logic [pwm_pkg::counter_width-1:0] shadow_clear [pwm_pkg::n_channels];

    // Software writes reach the comparators only at a period boundary or while stopped
    always_ff @(posedge clock) begin
        if (reload || counter_stopped) begin
            for (int i = 0; i < pwm_pkg::n_channels; i++) begin
                shadow_set[i]   <= threshold_set[i];
                shadow_clear[i] <= threshold_clear[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            match_set   <= '0;
            match_clear <= '0;
        end else begin
            for (int i = 0; i < pwm_pkg::n_channels; i++) begin
                match_set[i]   <= (count == shadow_set[i]);
                match_clear[i] <= (count == shadow_clear[i]);
            end
        end
    end

endmodule

// File: rtl/deadtime_generator.sv
// Dead-time stage of one channel; holds back rising edges of both outputs by the dead time
`timescale 1ns/1ps

module deadtime_generator (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               deadtime_enable,
    input  logic [pwm_pkg::deadtime_width-1:0] deadtime,
    input  logic                               pin_a,
    input  logic                               pin_b,
    output logic                               out_a,
    output logic                               out_b
);

    // Lane 0 carries the a side and lane 1 the b side
    logic [1:0]                        lane_in;
    logic [1:0]                        lane_out;
    logic [pwm_pkg::deadtime_width-1:0] steady_count [2];

    assign lane_in = {pin_b, pin_a};

    always_ff @(posedge clock) begin
        if (!reset) begin
            lane_out <= '0;
            for (int lane = 0; lane < 2; lane++)
                steady_count[lane] <= '0;
        end else begin
            for (int lane = 0; lane < 2; lane++) begin
                if (!deadtime_enable || !lane_in[lane]) begin
                    lane_out[lane]     <= lane_in[lane];
                    steady_count[lane] <= '0;
                end else if (!lane_out[lane]) begin
                    // Input has been high since the count started
                    if (steady_count[lane] == deadtime)
                        lane_out[lane] <= 1'b1;
                    else
                        steady_count[lane] <= steady_count[lane] + 1'b1;
                end
            end
        end
    end

    assign out_a = lane_out[0];
    assign out_b = lane_out[1];

endmodule

// File: rtl/enable_delay.sv
// Start-delay stage; counter_enable follows the run request after a programmed number of cycles
`timescale 1ns/1ps

module enable_delay (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            request,
    input  logic [pwm_pkg::shift_width-1:0] shift,
    output logic                            counter_enable
);

    logic [pwm_pkg::shift_width-1:0] wait_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter_enable <= 1'b0;
            wait_count     <= '0;
        end else if (!request) begin
            // A dropped request cancels a pending start as well
            counter_enable <= 1'b0;
            wait_count     <= '0;
        end else if (!counter_enable && wait_count == '0) begin
            // Fresh request, a zero shift starts the counter right away
            if (shift == '0)
                counter_enable <= 1'b1;
            else
                wait_count <= shift;
        end else if (wait_count != '0) begin
            wait_count <= wait_count - 1'b1;
            if (wait_count == 1)
                counter_enable <= 1'b1;
        end
    end

endmodule

// File: rtl/pin_control.sv
// Output stage of one channel; builds the complementary pin pair from the match bits
`timescale 1ns/1ps

module pin_control (
    input  logic       clock,
    input  logic       reset,
    input  logic       match_set,
    input  logic       match_clear,
    input  logic [1:0] output_enable,
    input  logic       counter_stopped,
    output logic       pin_a,
    output logic       pin_b
);

    logic pin_state;

    // A clear match wins over a set match on the same count
    always_ff @(posedge clock) begin
        if (!reset) begin
            pin_state <= 1'b0;
        end else if (match_clear) begin
            pin_state <= 1'b0;
        end else if (match_set) begin
            pin_state <= 1'b1;
        end
    end

    // Bit 0 of the enable gates pin_a and bit 1 gates pin_b
    assign pin_a = pin_state && output_enable[0] && !counter_stopped;
    assign pin_b = !pin_state && output_enable[1] && !counter_stopped;

endmodule

// File: rtl/pwm_chain.sv
// Top level of the three-channel PWM generator; wires the stages and the counter status
`timescale 1ns/1ps

module pwm_chain (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           write_strobe,
    input  pwm_pkg::addr_t                 address,
    input  pwm_pkg::data_t                 write_data,
    input  logic                           read_strobe,
    output pwm_pkg::data_t                 read_data,
    input  logic                           timebase,
    input  logic                           sync,
    input  logic                           external_run,
    input  logic                           stop_request,
    output logic                           counter_status,
    output logic [pwm_pkg::n_channels-1:0] out_a,
    output logic [pwm_pkg::n_channels-1:0] out_b
);

    logic                               run;
    logic [pwm_pkg::shift_width-1:0]    shift;
    logic [1:0]                         mode;
    logic [pwm_pkg::counter_width-1:0]  start_value;
    logic [pwm_pkg::counter_width-1:0]  stop_value;
    logic [pwm_pkg::counter_width-1:0]  threshold_set [pwm_pkg::n_channels];
    logic [pwm_pkg::counter_width-1:0]  threshold_clear [pwm_pkg::n_channels];
    logic [1:0]                         output_enable [pwm_pkg::n_channels];
    logic [pwm_pkg::deadtime_width-1:0] deadtime [pwm_pkg::n_channels];
    logic [pwm_pkg::n_channels-1:0]     deadtime_enable;
    logic                               counter_enable;
    logic                               counter_stopped;
    logic [pwm_pkg::counter_width-1:0]  count;
    logic                               reload;
    logic [pwm_pkg::n_channels-1:0]     match_set;
    logic [pwm_pkg::n_channels-1:0]     match_clear;
    logic [pwm_pkg::n_channels-1:0]     pin_a;
    logic [pwm_pkg::n_channels-1:0]     pin_b;
    logic                               run_request;

    // Either run source starts the counter, a stop request overrides both
    assign run_request = (run || external_run) && !stop_request;

    always_ff @(posedge clock) begin
        if (!reset)
            counter_stopped <= 1'b1;
        else
            counter_stopped <= !counter_enable;
    end

    assign counter_status = !counter_stopped;

    pwm_registers i_registers (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .address(address),
        .write_data(write_data),
        .read_strobe(read_strobe),
        .counter_running(counter_status),
        .read_data(read_data),
        .run(run),
        .shift(shift),
        .mode(mode),
        .start_value(start_value),
        .stop_value(stop_value),
        .threshold_set(threshold_set),
        .threshold_clear(threshold_clear),
        .output_enable(output_enable),
        .deadtime(deadtime),
        .deadtime_enable(deadtime_enable)
    );

    enable_delay i_enable_delay (
        .clock(clock),
        .reset(reset),
        .request(run_request),
        .shift(shift),
        .counter_enable(counter_enable)
    );

    pwm_counter i_counter (
        .clock(clock),
        .reset(reset),
        .counter_enable(counter_enable),
        .timebase(timebase),
        .sync(sync),
        .mode(mode),
        .start_value(start_value),
        .stop_value(stop_value),
        .count(count),
        .reload(reload)
    );

    compare_unit i_compare (
        .clock(clock),
        .reset(reset),
        .counter_stopped(counter_stopped),
        .count(count),
        .reload(reload),
        .threshold_set(threshold_set),
        .threshold_clear(threshold_clear),
        .match_set(match_set),
        .match_clear(match_clear)
    );

    for (genvar i = 0; i < pwm_pkg::n_channels; i++) begin : channel
        pin_control i_pin_control (
            .clock(clock),
            .reset(reset),
            .match_set(match_set[i]),
            .match_clear(match_clear[i]),
            .output_enable(output_enable[i]),
            .counter_stopped(counter_stopped),
            .pin_a(pin_a[i]),
            .pin_b(pin_b[i])
        );

        deadtime_generator i_deadtime (
            .clock(clock),
            .reset(reset),
            .deadtime_enable(deadtime_enable[i]),
            .deadtime(deadtime[i]),
            .pin_a(pin_a[i]),
            .pin_b(pin_b[i]),
            .out_a(out_a[i]),
            .out_b(out_b[i])
        );
    end

endmodule

// File: rtl/pwm_counter.sv
// Timebase-stepped PWM counter with up, down and up-down modes and a period-boundary reload
`timescale 1ns/1ps

module pwm_counter (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              counter_enable,
    input  logic                              timebase,
    input  logic                              sync,
    input  logic [1:0]                        mode,
    input  logic [pwm_pkg::counter_width-1:0] start_value,
    input  logic [pwm_pkg::counter_width-1:0] stop_value,
    output logic [pwm_pkg::counter_width-1:0] count,
    output logic                              reload
);

    logic [pwm_pkg::counter_width-1:0] next_count;
    logic                              count_up;
    logic                              next_up;

    // Next value of one timebase step for the selected mode
    always_comb begin
        next_count = count;
        next_up    = count_up;
        case (mode)
            pwm_pkg::mode_down: begin
                next_count = (count <= start_value) ? stop_value : count - 1'b1;
            end
            pwm_pkg::mode_updown: begin
                // The direction turns at both ends of the span
                if (count_up) begin
                    next_up    = (count < stop_value);
                    next_count = (count < stop_value) ? count + 1'b1 : count - 1'b1;
                end else begin
                    next_up    = (count <= start_value);
                    next_count = (count <= start_value) ? count + 1'b1 : count - 1'b1;
                end
            end
            default: begin
                next_count = (count >= stop_value) ? start_value : count + 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            count    <= '0;
            count_up <= 1'b1;
            reload   <= 1'b0;
        end else if (!counter_enable) begin
            count    <= start_value;
            count_up <= 1'b1;
            reload   <= 1'b0;
        end else if (sync) begin
            count    <= start_value;
            count_up <= 1'b1;
            reload   <= 1'b1;
        end else if (timebase) begin
            count    <= next_count;
            count_up <= next_up;
            reload   <= (next_count == start_value);
        end else begin
            reload   <= 1'b0;
        end
    end

endmodule

// File: rtl/pwm_pkg.sv
// Widths, register map and counter mode codes shared by every block of the PWM generator
package pwm_pkg;

    // Block dimensions
    localparam int n_channels     = 3;
    localparam int counter_width  = 16;
    localparam int deadtime_width = 8;
    localparam int shift_width    = 8;
    localparam int address_width  = 5;
    localparam int data_width     = 16;

    typedef logic [address_width-1:0] addr_t;
    typedef logic [data_width-1:0]    data_t;

    // Register word addresses
    localparam addr_t addr_control        = 5'd0;
    localparam addr_t addr_shift          = 5'd1;
    localparam addr_t addr_mode           = 5'd2;
    localparam addr_t addr_start          = 5'd3;
    localparam addr_t addr_stop           = 5'd4;
    localparam addr_t addr_threshold_base = 5'd5;
    localparam addr_t addr_enable_base    = 5'd11;
    localparam addr_t addr_deadtime_base  = 5'd14;

    // The dead-time registers carry their enable in the top data bit
    localparam int deadtime_enable_bit = 15;

    // Counter mode codes
    localparam logic [1:0] mode_up     = 2'd0;
    localparam logic [1:0] mode_down   = 2'd1;
    localparam logic [1:0] mode_updown = 2'd2;

endpackage

// File: rtl/pwm_registers.sv
// Register file of the PWM block; decodes strobed bus writes and registers the read data
`timescale 1ns/1ps

module pwm_registers (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 write_strobe,
    input  pwm_pkg::addr_t                       address,
    input  pwm_pkg::data_t                       write_data,
    input  logic                                 read_strobe,
    input  logic                                 counter_running,
    output pwm_pkg::data_t                       read_data,
    output logic                                 run,
    output logic [pwm_pkg::shift_width-1:0]      shift,
    output logic [1:0]                           mode,
    output logic [pwm_pkg::counter_width-1:0]    start_value,
    output logic [pwm_pkg::counter_width-1:0]    stop_value,
    output logic [pwm_pkg::counter_width-1:0]    threshold_set [pwm_pkg::n_channels],
    output logic [pwm_pkg::counter_width-1:0]    threshold_clear [pwm_pkg::n_channels],
    output logic [1:0]                           output_enable [pwm_pkg::n_channels],
    output logic [pwm_pkg::deadtime_width-1:0]   deadtime [pwm_pkg::n_channels],
    output logic [pwm_pkg::n_channels-1:0]       deadtime_enable
);

    pwm_pkg::data_t read_value;

    always_ff @(posedge clock) begin
        if (!reset) begin
            run             <= 1'b0;
            shift           <= '0;
            mode            <= pwm_pkg::mode_up;
            start_value     <= '0;
            stop_value      <= '0;
            deadtime_enable <= '0;
            for (int i = 0; i < pwm_pkg::n_channels; i++) begin
                threshold_set[i]   <= '0;
                threshold_clear[i] <= '0;
                output_enable[i]   <= '0;
                deadtime[i]        <= '0;
            end
        end else if (write_strobe) begin
            case (address)
                pwm_pkg::addr_control: run <= write_data[0];
                pwm_pkg::addr_shift:   shift <= write_data[pwm_pkg::shift_width-1:0];
                pwm_pkg::addr_mode:    mode <= write_data[1:0];
                pwm_pkg::addr_start:   start_value <= write_data;
                pwm_pkg::addr_stop:    stop_value <= write_data;
                default: ;
            endcase
            // Per-channel registers sit at strided offsets from their base addresses
            for (int i = 0; i < pwm_pkg::n_channels; i++) begin
                if (address == pwm_pkg::addr_threshold_base + pwm_pkg::addr_t'(2 * i))
                    threshold_set[i] <= write_data;
                if (address == pwm_pkg::addr_threshold_base + pwm_pkg::addr_t'(2 * i + 1))
                    threshold_clear[i] <= write_data;
                if (address == pwm_pkg::addr_enable_base + pwm_pkg::addr_t'(i))
                    output_enable[i] <= write_data[1:0];
                if (address == pwm_pkg::addr_deadtime_base + pwm_pkg::addr_t'(i)) begin
                    deadtime[i]        <= write_data[pwm_pkg::deadtime_width-1:0];
                    deadtime_enable[i] <= write_data[pwm_pkg::deadtime_enable_bit];
                end
            end
        end
    end

    // Read multiplexer, anything not decoded here reads as zero
    always_comb begin
        read_value = '0;
        case (address)
            pwm_pkg::addr_control: read_value = pwm_pkg::data_t'({counter_running, run});
            pwm_pkg::addr_shift:   read_value = pwm_pkg::data_t'(shift);
            pwm_pkg::addr_mode:    read_value = pwm_pkg::data_t'(mode);
            pwm_pkg::addr_start:   read_value = start_value;
            pwm_pkg::addr_stop:    read_value = stop_value;
            default: ;
        endcase
        for (int i = 0; i < pwm_pkg::n_channels; i++) begin
            if (address == pwm_pkg::addr_threshold_base + pwm_pkg::addr_t'(2 * i))
                read_value = threshold_set[i];
            if (address == pwm_pkg::addr_threshold_base + pwm_pkg::addr_t'(2 * i + 1))
                read_value = threshold_clear[i];
            if (address == pwm_pkg::addr_enable_base + pwm_pkg::addr_t'(i))
                read_value = pwm_pkg::data_t'(output_enable[i]);
            if (address == pwm_pkg::addr_deadtime_base + pwm_pkg::addr_t'(i)) begin
                read_value = pwm_pkg::data_t'(deadtime[i]);
                read_value[pwm_pkg::deadtime_enable_bit] = deadtime_enable[i];
            end
        end
    end

    // Read data holds its value between read strobes
    always_ff @(posedge clock) begin
        if (!reset) begin
            read_data <= '0;
        end else if (read_strobe) begin
            read_data <= read_value;
        end
    end

endmodule

// File: src.f
rtl/pwm_pkg.sv
rtl/pwm_registers.sv
rtl/enable_delay.sv
rtl/pwm_counter.sv
rtl/compare_unit.sv
rtl/pin_control.sv
rtl/deadtime_generator.sv
rtl/pwm_chain.sv
verification/pwm_chain_checker.sv
verification/pwm_chain_tb.sv

// File: verification/pwm_chain_checker.sv
// Concurrent checks on the PWM outputs, bound into every pwm_chain instance
`timescale 1ns/1ps

module pwm_chain_checker (
    input logic                           clock,
    input logic                           reset,
    input logic                           stop_request,
    input logic                           counter_status,
    input logic [pwm_pkg::n_channels-1:0] out_a,
    input logic [pwm_pkg::n_channels-1:0] out_b
);

    int failure_count = 0;

    // The two sides of a channel are complementary and never conduct together
    no_overlap: assert property (@(posedge clock) disable iff (!reset)
        (out_a & out_b) == '0)
        else begin
            $error("out_a %b and out_b %b are high together", out_a, out_b);
            failure_count++;
        end

    stop_drops_status: assert property (@(posedge clock) disable iff (!reset)
        stop_request && $past(stop_request) && $past(stop_request, 2) |-> !counter_status)
        else begin
            $error("counter_status still high under a held stop_request");
            failure_count++;
        end

    // A stopped counter forces every output low after the pipeline drains
    quiet_when_stopped: assert property (@(posedge clock) disable iff (!reset)
        !counter_status && !$past(counter_status) && !$past(counter_status, 2)
        |-> out_a == '0 && out_b == '0)
        else begin
            $error("outputs active while the counter is stopped");
            failure_count++;
        end

endmodule

bind pwm_chain pwm_chain_checker i_checker (
    .clock(clock),
    .reset(reset),
    .stop_request(stop_request),
    .counter_status(counter_status),
    .out_a(out_a),
    .out_b(out_b)
);

// File: verification/pwm_chain_tb.sv
// Testbench of the PWM block that programs it over the register strobes and checks the duty cycles
`timescale 1ns/1ps

module pwm_chain_tb;

    localparam int span = 40;
    localparam int dead_cycles = 4;

    logic                           clock;
    logic                           reset;
    logic                           write_strobe;
    pwm_pkg::addr_t                 address;
    pwm_pkg::data_t                 write_data;
    logic                           read_strobe;
    pwm_pkg::data_t                 read_data;
    logic                           timebase;
    logic                           sync;
    logic                           external_run;
    logic                           stop_request;
    logic                           counter_status;
    logic [pwm_pkg::n_channels-1:0] out_a;
    logic [pwm_pkg::n_channels-1:0] out_b;

    logic [15:0]                    lfsr_state = 16'd19;
    int                             error_count = 0;
    logic                           armed = 1'b0;
    logic [pwm_pkg::n_channels-1:0] last_a;
    int expected_a [pwm_pkg::n_channels];
    int expected_b [pwm_pkg::n_channels];
    int expected_period [pwm_pkg::n_channels];
    int high_a [pwm_pkg::n_channels];
    int high_b [pwm_pkg::n_channels];
    int length [pwm_pkg::n_channels];
    int rises_seen [pwm_pkg::n_channels];
    int periods_checked [pwm_pkg::n_channels];

    pwm_chain i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois LFSR that steps once for every random bit taken
    function automatic logic [15:0] random_bits(input int width);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    function automatic pwm_pkg::data_t register_mask(input int addr);
        if (addr == pwm_pkg::addr_shift)
            return 16'h00FF;
        if (addr == pwm_pkg::addr_mode)
            return 16'h0003;
        if (addr >= pwm_pkg::addr_start && addr < pwm_pkg::addr_enable_base)
            return 16'hFFFF;
        if (addr >= pwm_pkg::addr_enable_base && addr < pwm_pkg::addr_deadtime_base)
            return 16'h0003;
        if (addr >= pwm_pkg::addr_deadtime_base
                && addr < pwm_pkg::addr_deadtime_base + pwm_pkg::n_channels)
            return 16'h80FF;
        return 16'h0000;
    endfunction

    function automatic int period_length(input logic [1:0] mode, input int span_value);
        return (mode == pwm_pkg::mode_updown) ? 2 * span_value : span_value + 1;
    endfunction

    // Walks two periods of the count sequence and counts the high cycles of the second one
    function automatic int expected_high(input logic [1:0] mode, input int start, input int stop,
                                         input int set_at, input int clear_at, input int dead);
        int period;
        int phase;
        int value;
        int high;
        logic state;
        period = period_length(mode, stop - start);
        high = 0;
        state = 1'b0;
        for (int t = 0; t < 2 * period; t++) begin
            phase = t % period;
            if (mode == pwm_pkg::mode_down)
                value = stop - phase;
            else if (mode == pwm_pkg::mode_updown && phase > stop - start)
                value = start + period - phase;
            else
                value = start + phase;
            if (value == clear_at)
                state = 1'b0;
            else if (value == set_at)
                state = 1'b1;
            if (t >= period && state)
                high++;
        end
        return high - dead;
    endfunction

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic write_register(input pwm_pkg::addr_t addr, input pwm_pkg::data_t data);
        @(posedge clock);
        write_strobe <= 1'b1;
        address <= addr;
        write_data <= data;
        @(posedge clock);
        write_strobe <= 1'b0;
    endtask

    task automatic read_register(input pwm_pkg::addr_t addr, output pwm_pkg::data_t data);
        @(posedge clock);
        read_strobe <= 1'b1;
        address <= addr;
        @(posedge clock);
        read_strobe <= 1'b0;
        @(negedge clock);
        data = read_data;
    endtask

    task automatic wait_status(input logic level, input int limit, output int cycles);
        cycles = 0;
        @(negedge clock);
        while (counter_status != level && cycles < limit) begin
            cycles++;
            @(negedge clock);
        end
        if (counter_status != level)
            fail_on_timeout($sformatf("counter_status did not reach %0b", level));
    endtask

    task automatic wait_for_periods(input int periods, input int channels);
        int cycles;
        int done;
        cycles = 0;
        done = 0;
        while (done < channels && cycles < 20 * span * periods) begin
            @(negedge clock);
            cycles++;
            done = 0;
            for (int ch = 0; ch < pwm_pkg::n_channels; ch++)
                if (periods_checked[ch] >= periods)
                    done++;
        end
        if (done < channels)
            fail_on_timeout("the PWM outputs did not complete their periods");
    endtask

    // Comparing process that treats each interval between rising edges of out_a as one period
    always @(negedge clock) begin
        for (int ch = 0; ch < pwm_pkg::n_channels; ch++) begin
            if (!armed) begin
                rises_seen[ch] = 0;
                periods_checked[ch] = 0;
            end else begin
                if (out_a[ch] && !last_a[ch]) begin
                    // The first interval after a restart may be partial
                    if (rises_seen[ch] >= 2) begin
                        check_value($sformatf("out_a[%0d] high cycles", ch), high_a[ch],
                                    expected_a[ch]);
                        check_value($sformatf("out_b[%0d] high cycles", ch), high_b[ch],
                                    expected_b[ch]);
                        check_value($sformatf("out_a[%0d] period", ch), length[ch],
                                    expected_period[ch]);
                        periods_checked[ch]++;
                    end
                    rises_seen[ch]++;
                    high_a[ch] = 0;
                    high_b[ch] = 0;
                    length[ch] = 0;
                end
                high_a[ch] += int'(out_a[ch]);
                high_b[ch] += int'(out_b[ch]);
                length[ch]++;
            end
            last_a[ch] = out_a[ch];
        end
    end

    task automatic register_readback();
        pwm_pkg::data_t expected [2**pwm_pkg::address_width];
        pwm_pkg::data_t value;
        expected[0] = '0;
        for (int i = 1; i < 2**pwm_pkg::address_width; i++) begin
            value = random_bits(16);
            write_register(pwm_pkg::addr_t'(i), value);
            expected[i] = value & register_mask(i);
        end
        for (int i = 0; i < 2**pwm_pkg::address_width; i++) begin
            read_register(pwm_pkg::addr_t'(i), value);
            check_value($sformatf("read_data at address %0d", i), value, expected[i]);
        end
    endtask

    task automatic start_delay_check();
        int delay;
        int cycles;
        delay = 2 + random_bits(4);
        write_register(pwm_pkg::addr_shift, pwm_pkg::data_t'(delay));
        write_register(pwm_pkg::addr_control, 16'd1);
        wait_status(1'b1, delay + 10, cycles);
        // counter_enable rises shift+1 cycles after the run bit and counter_status one cycle later
        check_value("counter_status rise delay in cycles", cycles, delay + 2);
        write_register(pwm_pkg::addr_control, 16'd0);
        wait_status(1'b0, 4, cycles);
        write_register(pwm_pkg::addr_control, 16'd1);
        wait_status(1'b1, delay + 10, cycles);
        @(posedge clock);
        stop_request <= 1'b1;
        wait_status(1'b0, 4, cycles);
        write_register(pwm_pkg::addr_control, 16'd0);
        stop_request <= 1'b0;
    endtask

    // Out_a of channel 0 is disabled here while out_b must keep switching
    task automatic disabled_side_check();
        int a_high;
        int b_rises;
        logic b_last;
        a_high = 0;
        b_rises = 0;
        b_last = out_b[0];
        for (int i = 0; i < 4 * span; i++) begin
            @(negedge clock);
            a_high += int'(out_a[0]);
            if (out_b[0] && !b_last)
                b_rises++;
            b_last = out_b[0];
        end
        check_value("out_a[0] high cycles with its enable cleared", a_high, 0);
        assert (b_rises >= 2) else begin
            $display("out_b[0] stopped switching while out_a[0] was disabled");
            error_count++;
        end
    endtask

    task automatic run_pattern(input logic [1:0] mode, input int dead, input logic a_disabled);
        int start;
        int period;
        int first;
        int second;
        int set_at;
        int clear_at;
        armed = 1'b0;
        write_register(pwm_pkg::addr_control, 16'd0);
        start = 10 + random_bits(4);
        period = period_length(mode, span);
        write_register(pwm_pkg::addr_mode, pwm_pkg::data_t'(mode));
        write_register(pwm_pkg::addr_start, pwm_pkg::data_t'(start));
        write_register(pwm_pkg::addr_stop, pwm_pkg::data_t'(start + span));
        for (int ch = 0; ch < pwm_pkg::n_channels; ch++) begin
            first = 2 + random_bits(4);
            second = first + 8 + random_bits(3);
            // One random bit decides whether the set threshold comes first in the count
            if (random_bits(1)) begin
                set_at = start + first;
                clear_at = start + second;
            end else begin
                set_at = start + second;
                clear_at = start + first;
            end
            write_register(pwm_pkg::addr_t'(pwm_pkg::addr_threshold_base + 2 * ch),
                           pwm_pkg::data_t'(set_at));
            write_register(pwm_pkg::addr_t'(pwm_pkg::addr_threshold_base + 2 * ch + 1),
                           pwm_pkg::data_t'(clear_at));
            write_register(pwm_pkg::addr_t'(pwm_pkg::addr_enable_base + ch),
                           (a_disabled && ch == 0) ? 16'd2 : 16'd3);
            write_register(pwm_pkg::addr_t'(pwm_pkg::addr_deadtime_base + ch),
                           (dead > 0) ? (16'h8000 | pwm_pkg::data_t'(dead)) : 16'd0);
            expected_a[ch] = expected_high(mode, start, start + span, set_at, clear_at, dead);
            expected_b[ch] = period - dead
                             - expected_high(mode, start, start + span, set_at, clear_at, 0);
            expected_period[ch] = period;
        end
        write_register(pwm_pkg::addr_control, 16'd1);
        armed = 1'b1;
        wait_for_periods(3, a_disabled ? pwm_pkg::n_channels - 1 : pwm_pkg::n_channels);
        if (a_disabled)
            disabled_side_check();
    endtask

    initial begin
        reset = 1'b0;
        write_strobe = 1'b0;
        address = '0;
        write_data = '0;
        read_strobe = 1'b0;
        timebase = 1'b0;
        sync = 1'b0;
        external_run = 1'b0;
        stop_request = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b1;
        register_readback();
        start_delay_check();
        @(posedge clock);
        timebase <= 1'b1;
        run_pattern(pwm_pkg::mode_up, 0, 1'b0);
        run_pattern(pwm_pkg::mode_up, dead_cycles, 1'b0);
        run_pattern(pwm_pkg::mode_down, 0, 1'b0);
        run_pattern(pwm_pkg::mode_updown, dead_cycles, 1'b0);
        run_pattern(pwm_pkg::mode_up, 0, 1'b1);
        armed = 1'b0;
        $display("Run complete: %0d check errors, %0d assertion failures",
                 error_count, i_dut.i_checker.failure_count);
        if (error_count == 0 && i_dut.i_checker.failure_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
